// File: hdl/cpu_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// build-time settings for the rv32i pipeline
// memory depths, reset pc, ecall halt code
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// instruction memory depth in 32-bit words
`define CPU_IMEM_WORDS 64
// data memory depth in 32-bit words
`define CPU_DMEM_WORDS 64

`define CPU_RESET_PC 32'h0000_0000 // first fetch address
`define CPU_HALT_CODE 32'd10       // x17 value that turns ecall into a halt

`endif

// File: hdl/cpu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the rv32i pipeline
// opcodes, alu class, funct3 codes
// instruction formats and their packed union
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cpu_pkg;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011, // r-type alu
    op_imm    = 7'b0010011, // i-type alu
    op_load   = 7'b0000011, // lw
    op_store  = 7'b0100011, // sw
    op_system = 7'b1110011  // ecall
  } opcode_e;

  // what the alu should look at
  typedef enum logic [1:0] {
    cls_addr = 2'b00, // plain add for load/store address
    cls_reg  = 2'b01, // funct7 + funct3 of r-type
    cls_imm  = 2'b10  // funct3 of i-type, funct7 only for sra
  } alu_class_e;

  // funct3 codes
  localparam logic [2:0] f3_add = 3'b000; // add / sub
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_srl = 3'b101; // srl / sra
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_s;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_s;

  typedef struct packed {
    logic [6:0] imm_hi; // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo; // imm[4:0]
    opcode_e    opcode;
  } s_fmt_s;

  // one fetched word, three ways to read it
  typedef union packed {
    r_fmt_s r;
    i_fmt_s i;
    s_fmt_s s;
  } instr_u;

endpackage

// File: hdl/control_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control decoder
// opcode to stage control levels and alu class
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module control_decoder (
  input  cpu_pkg::instr_u     instr,
  output logic                mem_read,
  output logic                mem_write,
  output logic                mem_to_reg,
  output logic                alu_src,
  output logic                reg_write,
  output logic                is_ecall,
  output cpu_pkg::alu_class_e alu_class
);

  always_comb begin
    // bubble unless the opcode says otherwise
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    mem_to_reg = 1'b0;
    alu_src    = 1'b0;
    reg_write  = 1'b0;
    is_ecall   = 1'b0;
    alu_class  = cpu_pkg::cls_addr;
    case (instr.r.opcode)
      cpu_pkg::op_reg: begin
        reg_write = 1'b1;
        alu_class = cpu_pkg::cls_reg; // rs2 operand
      end
      cpu_pkg::op_imm: begin
        reg_write = 1'b1;
        alu_src   = 1'b1; // immediate operand
        alu_class = cpu_pkg::cls_imm;
      end
      cpu_pkg::op_load: begin
        mem_read   = 1'b1;
        mem_to_reg = 1'b1;
        reg_write  = 1'b1;
        alu_src    = 1'b1; // base + offset
      end
      cpu_pkg::op_store: begin
        mem_write = 1'b1;
        alu_src   = 1'b1;
      end
      cpu_pkg::op_system: begin
        // ecall only, ebreak and csr ops fall through as bubbles
        is_ecall = (instr.i.imm == 12'd0) && (instr.i.funct3 == 3'd0);
      end
      default: ;
    endcase
  end

endmodule

// File: hdl/imm_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// immediate generator
// sign-extended i-type and s-type immediates
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module imm_gen (
  input  cpu_pkg::instr_u instr,
  output logic [31:0]     imm
);

  always_comb begin
    case (instr.i.opcode)
      cpu_pkg::op_imm: begin
        if (instr.i.funct3 == cpu_pkg::f3_sll || instr.i.funct3 == cpu_pkg::f3_srl)
          imm = {27'd0, instr.i.imm[4:0]}; // shamt only, funct7 bits dropped
        else
          imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      cpu_pkg::op_load:  imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      cpu_pkg::op_store: imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
      default:           imm = 32'd0; // r-type and system have none
    endcase
  end

endmodule

// File: hdl/alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu with built-in funct decode
// add sub and or xor slt sll srl sra
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module alu (
  input  cpu_pkg::alu_class_e alu_class,
  input  logic [3:0]          functs, // {funct7[5], funct3}
  input  logic [31:0]         a,
  input  logic [31:0]         b,
  output logic [31:0]         result
);

  logic [4:0] shamt;
  logic       alt;   // funct7 bit 5

  assign shamt = b[4:0];
  assign alt   = functs[3];

  always_comb begin
    if (alu_class == cpu_pkg::cls_reg || alu_class == cpu_pkg::cls_imm) begin
      case (functs[2:0])
        cpu_pkg::f3_add: begin
          // sub exists only as r-type, addi ignores the bit
          if (alu_class == cpu_pkg::cls_reg && alt) result = a - b;
          else result = a + b;
        end
        cpu_pkg::f3_sll: result = a << shamt;
        cpu_pkg::f3_slt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        cpu_pkg::f3_xor: result = a ^ b;
        cpu_pkg::f3_srl: begin
          if (alt) result = $signed(a) >>> shamt; // sra, both classes
          else result = a >> shamt;
        end
        cpu_pkg::f3_or:  result = a | b;
        cpu_pkg::f3_and: result = a & b;
        default:         result = 32'd0; // sltu not supported
      endcase
    end else begin
      result = a + b; // address calc for lw / sw
    end
  end

endmodule

// File: hdl/register_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32x32 register file
// two read ports, debug read, write-through
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module register_file (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic [31:0] rd_din,
  input  logic        write_enable,
  output logic [31:0] rs1_dout,
  output logic [31:0] rs2_dout,
  input  logic [4:0]  dbg_addr,
  output logic [31:0] dbg_data
);

  logic [31:0] regs [0:31];

  // x0 reads zero, a same-cycle write shows through
  function automatic logic [31:0] read_reg(input logic [4:0] addr);
    logic [31:0] val;
    if (addr == 5'd0) val = 32'd0;
    else if (write_enable && addr == rd) val = rd_din;
    else val = regs[addr];
    return val;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= 32'd0;
    end else if (write_enable && rd != 5'd0) begin
      regs[rd] <= rd_din; // x0 never written
    end
  end

  always_comb begin
    rs1_dout = read_reg(rs1);
    rs2_dout = read_reg(rs2);
    dbg_data = read_reg(dbg_addr); // testbench peek
  end

endmodule

// File: hdl/data_memory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word-addressed data ram
// sync write, combinational read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "cpu_settings.svh"

module data_memory (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] addr,
  input  logic [31:0] din,
  input  logic        mem_read,
  input  logic        mem_write,
  output logic [31:0] dout
);

  localparam int aw = $clog2(`CPU_DMEM_WORDS);

  logic [31:0]   mem [0:`CPU_DMEM_WORDS-1];
  logic [aw-1:0] idx;

  assign idx = addr[aw+1:2]; // byte offset ignored, words only

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_DMEM_WORDS; i++) mem[i] <= 32'd0;
    end else if (mem_write) begin
      mem[idx] <= din;
    end
  end

  assign dout = mem_read ? mem[idx] : 32'd0;

endmodule

// File: hdl/pipeline_cpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// five-stage rv32i pipeline top
// pc, program-loadable imem, if/id id/ex ex/mem mem/wb
// execute and writeback muxes, sticky halt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "cpu_settings.svh"

module pipeline_cpu (
  input  logic        clk,
  input  logic        reset,
  input  logic        prog_we,
  input  logic [5:0]  prog_addr,
  input  logic [31:0] prog_data,
  input  logic [4:0]  dbg_addr,
  output logic [31:0] dbg_data,
  output logic        halted
);

  localparam int imem_aw = $clog2(`CPU_IMEM_WORDS);

  // fetch
  logic [31:0] pc;
  logic [31:0] imem [0:`CPU_IMEM_WORDS-1];
  logic [31:0] fetch_word;

  // decode
  cpu_pkg::instr_u     if_id_instr;
  logic                dec_mem_read, dec_mem_write, dec_mem_to_reg;
  logic                dec_alu_src, dec_reg_write, dec_is_ecall;
  cpu_pkg::alu_class_e dec_alu_class;
  logic [31:0]         dec_imm;
  logic [4:0]          rs1_sel;
  logic [31:0]         rs1_data, rs2_data;
  logic                halt_hit;

  // id/ex bank
  logic                id_ex_mem_read, id_ex_mem_write, id_ex_mem_to_reg;
  logic                id_ex_alu_src, id_ex_reg_write, id_ex_halt;
  cpu_pkg::alu_class_e id_ex_alu_class;
  logic [31:0]         id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
  logic [3:0]          id_ex_functs;
  logic [4:0]          id_ex_rd;
  logic [31:0]         alu_b, alu_result;

  // ex/mem bank
  logic        ex_mem_mem_read, ex_mem_mem_write, ex_mem_mem_to_reg;
  logic        ex_mem_reg_write, ex_mem_halt;
  logic [31:0] ex_mem_alu_out, ex_mem_store_data;
  logic [4:0]  ex_mem_rd;
  logic [31:0] load_data;

  // mem/wb bank
  logic        mem_wb_mem_to_reg, mem_wb_reg_write;
  logic [31:0] mem_wb_alu_out, mem_wb_load_data;
  logic [4:0]  mem_wb_rd;
  logic [31:0] wb_data;

  logic halted_q;

  // program port, only used while held in reset
  always_ff @(posedge clk) begin
    if (prog_we) imem[prog_addr] <= prog_data;
  end

  assign fetch_word = imem[pc[imem_aw+1:2]];

  always_ff @(posedge clk) begin
    if (reset) pc <= `CPU_RESET_PC;
    else if (!halted_q) pc <= pc + 32'd4; // frozen once halted
  end

  always_ff @(posedge clk) begin
    if (reset) if_id_instr <= '0; // zero opcode decodes as bubble
    else if_id_instr <= fetch_word;
  end

  control_decoder i_control_decoder (
    .instr      (if_id_instr),
    .mem_read   (dec_mem_read),
    .mem_write  (dec_mem_write),
    .mem_to_reg (dec_mem_to_reg),
    .alu_src    (dec_alu_src),
    .reg_write  (dec_reg_write),
    .is_ecall   (dec_is_ecall),
    .alu_class  (dec_alu_class)
  );

  imm_gen i_imm_gen (
    .instr (if_id_instr),
    .imm   (dec_imm)
  );

  assign rs1_sel  = dec_is_ecall ? 5'd17 : if_id_instr.r.rs1; // ecall checks a7
  assign halt_hit = dec_is_ecall && (rs1_data == `CPU_HALT_CODE);

  register_file i_register_file (
    .clk          (clk),
    .reset        (reset),
    .rs1          (rs1_sel),
    .rs2          (if_id_instr.r.rs2),
    .rd           (mem_wb_rd),
    .rd_din       (wb_data),
    .write_enable (mem_wb_reg_write),
    .rs1_dout     (rs1_data),
    .rs2_dout     (rs2_data),
    .dbg_addr     (dbg_addr),
    .dbg_data     (dbg_data)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex_mem_read   <= 1'b0;
      id_ex_mem_write  <= 1'b0;
      id_ex_mem_to_reg <= 1'b0;
      id_ex_alu_src    <= 1'b0;
      id_ex_reg_write  <= 1'b0;
      id_ex_halt       <= 1'b0;
      id_ex_alu_class  <= cpu_pkg::cls_addr;
    end else begin
      id_ex_mem_read   <= dec_mem_read;
      id_ex_mem_write  <= dec_mem_write;
      id_ex_mem_to_reg <= dec_mem_to_reg;
      id_ex_alu_src    <= dec_alu_src;
      id_ex_reg_write  <= dec_reg_write;
      id_ex_halt       <= halt_hit;
      id_ex_alu_class  <= dec_alu_class;
    end
  end

  always_ff @(posedge clk) begin
    id_ex_rs1_data <= rs1_data;
    id_ex_rs2_data <= rs2_data;
    id_ex_imm      <= dec_imm;
    id_ex_functs   <= {if_id_instr.r.funct7[5], if_id_instr.r.funct3};
    id_ex_rd       <= if_id_instr.r.rd;
  end

  assign alu_b = id_ex_alu_src ? id_ex_imm : id_ex_rs2_data; // operand mux

  alu i_alu (
    .alu_class (id_ex_alu_class),
    .functs    (id_ex_functs),
    .a         (id_ex_rs1_data),
    .b         (alu_b),
    .result    (alu_result)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem_mem_read   <= 1'b0;
      ex_mem_mem_write  <= 1'b0;
      ex_mem_mem_to_reg <= 1'b0;
      ex_mem_reg_write  <= 1'b0;
      ex_mem_halt       <= 1'b0;
    end else begin
      ex_mem_mem_read   <= id_ex_mem_read;
      ex_mem_mem_write  <= id_ex_mem_write;
      ex_mem_mem_to_reg <= id_ex_mem_to_reg;
      ex_mem_reg_write  <= id_ex_reg_write;
      ex_mem_halt       <= id_ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem_alu_out    <= alu_result;
    ex_mem_store_data <= id_ex_rs2_data; // sw data
    ex_mem_rd         <= id_ex_rd;
  end

  data_memory i_data_memory (
    .clk       (clk),
    .reset     (reset),
    .addr      (ex_mem_alu_out),
    .din       (ex_mem_store_data),
    .mem_read  (ex_mem_mem_read),
    .mem_write (ex_mem_mem_write),
    .dout      (load_data)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb_mem_to_reg <= 1'b0;
      mem_wb_reg_write  <= 1'b0;
    end else begin
      mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
      mem_wb_reg_write  <= ex_mem_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    mem_wb_alu_out   <= ex_mem_alu_out;
    mem_wb_load_data <= load_data;
    mem_wb_rd        <= ex_mem_rd;
  end

  assign wb_data = mem_wb_mem_to_reg ? mem_wb_load_data : mem_wb_alu_out;

  // set as the ecall leaves mem, held until reset
  always_ff @(posedge clk) begin
    if (reset) halted_q <= 1'b0;
    else if (ex_mem_halt) halted_q <= 1'b1;
  end

  assign halted = halted_q;

endmodule

// File: testbench/tb_pipeline_cpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the rv32i pipeline
// instruction encoders, reference model, lcg
// directed tests, watchdog, result line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "cpu_settings.svh"

module tb_pipeline_cpu;

  localparam int clk_period = 20;
  localparam int num_tests  = 6;
  localparam int halt_limit = 60; // cycles from reset release to halted

  // rv32i opcodes and funct3 codes
  localparam logic [6:0] opc_reg   = 7'h33;
  localparam logic [6:0] opc_imm   = 7'h13;
  localparam logic [6:0] opc_load  = 7'h03;
  localparam logic [6:0] opc_store = 7'h23;
  localparam logic [31:0] nop      = 32'h0000_0013; // addi x0, x0, 0
  localparam logic [2:0] f_add = 3'd0, f_sll = 3'd1, f_slt = 3'd2, f_xor = 3'd4;
  localparam logic [2:0] f_sr  = 3'd5, f_or  = 3'd6, f_and = 3'd7;

  logic        clk, reset, prog_we, halted;
  logic [5:0]  prog_addr;
  logic [31:0] prog_data, dbg_data;
  logic [4:0]  dbg_addr;

  logic [31:0] prog [$];                             // program under construction
  logic [31:0] model_x [0:31];                       // expected registers
  logic [31:0] model_mem [0:`CPU_DMEM_WORDS-1];      // expected data memory
  logic [31:0] rng_state = 32'h41c3;
  int          errors = 0;
  int          checks = 0;

  pipeline_cpu i_pipeline_cpu (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .dbg_addr  (dbg_addr),
    .dbg_data  (dbg_data),
    .halted    (halted)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [11:0] rand_imm12();
    logic [31:0] r;
    r = lcg_next();
    return r[23:12]; // upper bits mix better
  endfunction

  function automatic logic [31:0] enc_r(input logic alt, input logic [2:0] f3,
                                        input logic [4:0] rd, rs1, rs2);
    return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, opc_reg};
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                        input logic [11:0] imm, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
  endfunction

  // rv32i integer semantics with alt as funct7 bit 5
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, b);
    logic [31:0] res;
    case (f3)
      f_add:   res = alt ? a - b : a + b;
      f_sll:   res = a << b[4:0];
      f_slt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      f_xor:   res = a ^ b;
      f_sr:    res = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      f_or:    res = a | b;
      f_and:   res = a & b;
      default: res = 32'd0;
    endcase
    return res;
  endfunction

  task automatic clear_program();
    prog.delete();
    for (int i = 0; i < 32; i++) model_x[i] = 32'd0;
    for (int i = 0; i < `CPU_DMEM_WORDS; i++) model_mem[i] = 32'd0;
  endtask

  task automatic put_gap();
    repeat (3) prog.push_back(nop); // producer to consumer spacing
  endtask

  task automatic put_r(input logic alt, input logic [2:0] f3, input logic [4:0] rd, rs1, rs2);
    prog.push_back(enc_r(alt, f3, rd, rs1, rs2));
    if (rd != 5'd0) model_x[rd] = ref_alu(f3, alt, model_x[rs1], model_x[rs2]);
  endtask

  task automatic put_i(input logic [2:0] f3, input logic [4:0] rd, rs1, input logic [11:0] imm);
    logic [31:0] sx;
    sx = {{20{imm[11]}}, imm};
    prog.push_back(enc_i(f3, rd, rs1, imm, opc_imm));
    if (rd != 5'd0) model_x[rd] = ref_alu(f3, 1'b0, model_x[rs1], sx);
  endtask

  task automatic put_sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    logic [31:0] addr;
    addr = model_x[rs1] + {{20{imm[11]}}, imm};
    model_mem[addr[7:2]] = model_x[rs2]; // word index from bits 7:2
    prog.push_back(enc_s(rs2, rs1, imm));
  endtask

  task automatic put_lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
    logic [31:0] addr;
    addr = model_x[rs1] + {{20{imm[11]}}, imm};
    if (rd != 5'd0) model_x[rd] = model_mem[addr[7:2]];
    prog.push_back(enc_i(3'b010, rd, rs1, imm, opc_load));
  endtask

  // a7 = halt code, then ecall and trailing nops
  task automatic put_halt();
    put_i(f_add, 5'd17, 5'd0, 12'(`CPU_HALT_CODE));
    put_gap();
    prog.push_back(32'h0000_0073);
    repeat (4) prog.push_back(nop);
  endtask

  // one debug read per falling edge
  task automatic check_regs(input string name);
    for (int r = 0; r < 32; r++) begin
      @(negedge clk);
      dbg_addr = 5'(r);
      #1;
      checks++;
      if (dbg_data !== model_x[r]) begin
        errors++;
        $display("mismatch at %0t: %s x%0d = %h, expected %h",
                 $time, name, r, dbg_data, model_x[r]);
      end
    end
  endtask

  // load under reset, release, wait for halted, compare all registers
  task automatic run_program(input string name);
    int cycles;
    @(negedge clk);
    reset = 1'b1;
    foreach (prog[i]) begin
      prog_we   = 1'b1;
      prog_addr = 6'(i);
      prog_data = prog[i];
      @(negedge clk);
    end
    prog_we = 1'b0;
    repeat (4) @(negedge clk);
    reset  = 1'b0;
    checks++;
    if (halted !== 1'b0) begin
      errors++; // previous run left halted high
      $display("mismatch at %0t: %s halted = %b after reset, expected 0",
               $time, name, halted);
    end
    cycles = 0;
    while (!halted && cycles < halt_limit) begin
      @(negedge clk);
      cycles++;
    end
    checks++;
    if (!halted) begin
      errors++;
      $display("error at %0t: %s never raised halted within %0d cycles",
               $time, name, halt_limit);
    end
    check_regs(name);
  endtask

  task automatic test_reset_state();
    clear_program();
    repeat (4) @(negedge clk); // reset held since time zero
    reset = 1'b0;
    checks++;
    if (halted !== 1'b0) begin
      errors++;
      $display("mismatch at %0t: halted = %b after reset, expected 0", $time, halted);
    end
    check_regs("reset"); // nothing loaded yet, so nothing retires
  endtask

  task automatic test_imm_ops();
    clear_program();
    put_i(f_add, 5'd1, 5'd0, rand_imm12());
    put_gap();
    put_i(f_add, 5'd5, 5'd1, rand_imm12() | 12'h800); // negative addi
    put_i(f_and, 5'd6, 5'd1, rand_imm12());
    put_i(f_or,  5'd7, 5'd1, rand_imm12());
    put_i(f_xor, 5'd8, 5'd1, rand_imm12());
    put_i(f_slt, 5'd9, 5'd1, rand_imm12());
    put_i(f_slt, 5'd10, 5'd1, rand_imm12() | 12'h800);
    put_halt();
    run_program("imm ops");
  endtask

  task automatic test_reg_ops();
    logic [11:0] sh;
    clear_program();
    sh = rand_imm12();
    put_i(f_add, 5'd1, 5'd0, rand_imm12() | 12'h800);  // negative operand
    put_i(f_add, 5'd2, 5'd0, rand_imm12() & 12'h7ff);  // positive operand
    put_i(f_add, 5'd3, 5'd0, {7'd0, sh[4:0]});         // shift amount
    put_gap();
    put_r(1'b0, f_add, 5'd20, 5'd1, 5'd2);
    put_r(1'b1, f_add, 5'd21, 5'd1, 5'd2);  // sub
    put_r(1'b0, f_and, 5'd22, 5'd1, 5'd2);
    put_r(1'b0, f_or,  5'd23, 5'd1, 5'd2);
    put_r(1'b0, f_xor, 5'd24, 5'd1, 5'd2);
    put_r(1'b0, f_slt, 5'd25, 5'd1, 5'd2);  // neg < pos
    put_r(1'b0, f_slt, 5'd26, 5'd2, 5'd1);
    put_r(1'b0, f_sll, 5'd27, 5'd1, 5'd3);
    put_r(1'b0, f_sr,  5'd28, 5'd1, 5'd3);  // srl
    put_r(1'b1, f_sr,  5'd29, 5'd1, 5'd3);  // sra
    put_halt();
    run_program("reg ops");
  endtask

  task automatic test_load_store();
    clear_program();
    for (int r = 1; r <= 4; r++) put_i(f_add, 5'(r), 5'd0, rand_imm12());
    put_i(f_add, 5'd10, 5'd0, 12'd32); // base address
    put_gap();
    put_sw(5'd1, 5'd10, 12'd0);
    put_sw(5'd2, 5'd10, 12'd4);
    put_sw(5'd3, 5'd10, 12'hff8);      // -8
    put_sw(5'd4, 5'd10, 12'd20);
    put_lw(5'd5, 5'd10, 12'd20);
    put_lw(5'd6, 5'd10, 12'd0);
    put_lw(5'd7, 5'd10, 12'hff8);
    put_lw(5'd8, 5'd10, 12'd4);
    put_lw(5'd9, 5'd10, 12'd12);       // never written
    put_halt();
    run_program("load store");
  endtask

  task automatic test_ecall_halt();
    clear_program();
    put_i(f_add, 5'd17, 5'd0, 12'd5); // not the halt code
    put_gap();
    prog.push_back(32'h0000_0073);
    put_gap();
    put_i(f_add, 5'd1, 5'd0, rand_imm12());
    put_i(f_add, 5'd2, 5'd0, rand_imm12());
    put_gap();
    put_r(1'b0, f_add, 5'd3, 5'd1, 5'd2); // only lands if no early halt
    put_halt();
    run_program("ecall halt");
    repeat (3) @(negedge clk);
    checks++;
    if (!halted) begin
      errors++;
      $display("error at %0t: halted dropped without a reset", $time);
    end
  endtask

  task automatic test_x0();
    clear_program();
    put_i(f_add, 5'd0, 5'd0, rand_imm12() | 12'h001); // nonzero write to x0
    put_i(f_add, 5'd1, 5'd0, rand_imm12());
    put_gap();
    put_r(1'b0, f_add, 5'd0, 5'd1, 5'd1);
    repeat (2) prog.push_back(nop);
    put_r(1'b0, f_add, 5'd2, 5'd0, 5'd1); // reads x0 as the add above writes back
    put_i(f_or, 5'd3, 5'd0, 12'd0);
    put_halt();
    run_program("x0");
  endtask

  // watchdog allows 100 cycles per test
  initial begin
    #(num_tests * 100 * clk_period);
    $display("error at %0t: watchdog expired, run did not finish", $time);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    prog_we   = 1'b0;
    prog_addr = 6'd0;
    prog_data = 32'd0;
    dbg_addr  = 5'd0;
    test_reset_state();
    test_imm_ops();
    test_reg_ops();
    test_load_store();
    test_ecall_halt();
    test_x0();
    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/control_decoder.sv
hdl/imm_gen.sv
hdl/alu.sv
hdl/register_file.sv
hdl/data_memory.sv
hdl/pipeline_cpu.sv
testbench/tb_pipeline_cpu.sv

// File: Makefile
# Verilator build and run of the rv32i pipeline testbench
TOP := tb_pipeline_cpu

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# pass only if the run prints the pass line
test:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
